//--- mcu_buffer.f
src/jpeg_mcu_pkg.sv
src/dp_ram_be.sv
src/mcu_write_port.sv
src/mcu_read_sequencer.sv
src/mcu_output_stage.sv
src/mcu_buffer.sv
verification/mcu_buffer_tb.sv

//--- verification/mcu_buffer_tb.sv
module mcu_buffer_tb;

    localparam int SENSOR_X_SIZE   = 64;
    localparam int SENSOR_Y_SIZE   = 64;
    localparam int XW              = $clog2(SENSOR_X_SIZE);
    localparam int YW              = $clog2(SENSOR_Y_SIZE);
    // 32x48 image, two macroblocks across, three stripes down
    localparam int IMG_W           = 32;
    localparam int IMG_H           = 48;
    localparam int STRIPE_BEATS    = IMG_W * jpeg_mcu_pkg::STRIPE_LINES;
    localparam int FRAME_BEATS     = IMG_W * IMG_H;
    localparam int ROWS_PER_MB     = 6 * jpeg_mcu_pkg::MCU_ROWS;
    localparam int ROWS_PER_STRIPE = ROWS_PER_MB * (IMG_W / 16);
    localparam int WAIT_LIMIT      = 4000;
    localparam int NUM_CASES       = 6;

    // one test case, random rates in percent
    typedef struct packed {
        logic [7:0]  hold_pct;
        logic [7:0]  stall_pct;
        logic [15:0] init_stall;
        logic [15:0] exp_rows;
        logic        exp_full;
    } case_t;

    logic                   clk = 1'b0;
    logic                   resetn;
    jpeg_mcu_pkg::pixel_t   yuvrgb_in_y_i;
    jpeg_mcu_pkg::pixel_t   yuvrgb_in_u_i;
    jpeg_mcu_pkg::pixel_t   yuvrgb_in_v_i;
    logic [2:0]             yuvrgb_in_valid_i;
    logic [XW-1:0]          pixel_count_i;
    logic [YW-1:0]          line_count_i;
    logic                   yuvrgb_in_hold_o;
    jpeg_mcu_pkg::row_t     di_o;
    logic                   di_valid_o;
    logic [2:0]             di_cnt_o;
    logic                   di_hold_i;
    logic [XW-1:0]          x_size_m1_i;
    logic [YW-1:0]          y_size_m1_i;

    case_t  cases [NUM_CASES];
    integer seed = 32'hd2f77fd3;
    int     errors = 0;
    int     checks = 0;
    int     rows_taken;
    bit     full_seen;
    bit     timed_out = 1'b0;

    mcu_buffer i_mcu_buffer (
        .clk               (clk),
        .resetn            (resetn),
        .yuvrgb_in_y_i     (yuvrgb_in_y_i),
        .yuvrgb_in_u_i     (yuvrgb_in_u_i),
        .yuvrgb_in_v_i     (yuvrgb_in_v_i),
        .yuvrgb_in_valid_i (yuvrgb_in_valid_i),
        .pixel_count_i     (pixel_count_i),
        .line_count_i      (line_count_i),
        .yuvrgb_in_hold_o  (yuvrgb_in_hold_o),
        .di_o              (di_o),
        .di_valid_o        (di_valid_o),
        .di_cnt_o          (di_cnt_o),
        .di_hold_i         (di_hold_i),
        .x_size_m1_i       (x_size_m1_i),
        .y_size_m1_i       (y_size_m1_i)
    );

    always #2 clk = ~clk;

    // pixel rules of the test image
    function automatic jpeg_mcu_pkg::pixel_t luma_at(input int x, input int y);
        return jpeg_mcu_pkg::pixel_t'((3 * x + 5 * y) % 256);
    endfunction

    function automatic jpeg_mcu_pkg::pixel_t u_at(input int x, input int y);
        return jpeg_mcu_pkg::pixel_t'((x + 7 * y + 40) % 256);
    endfunction

    function automatic jpeg_mcu_pkg::pixel_t v_at(input int x, input int y);
        return jpeg_mcu_pkg::pixel_t'((5 * x + y + 90) % 256);
    endfunction

    function automatic jpeg_mcu_pkg::sample_t level_shift(input jpeg_mcu_pkg::pixel_t p);
        return jpeg_mcu_pkg::sample_t'(int'(p) - 128);
    endfunction

    // expected output row r of the frame, blocks Y0 Y1 Y2 Y3 U V per macroblock
    function automatic jpeg_mcu_pkg::row_t model_row(input int r);
        jpeg_mcu_pkg::row_t row;
        int stripe;
        int mb;
        int blk;
        int line;
        int i;
        stripe = r / ROWS_PER_STRIPE;
        mb     = (r % ROWS_PER_STRIPE) / ROWS_PER_MB;
        blk    = (r % ROWS_PER_MB) / jpeg_mcu_pkg::MCU_ROWS;
        line   = r % jpeg_mcu_pkg::MCU_ROWS;
        for (i = 0; i < 8; i++) begin
            if (blk < 4) begin
                row[i*8 +: 8] = level_shift(luma_at(mb * 16 + (blk % 2) * 8 + i,
                                                    stripe * 16 + (blk / 2) * 8 + line));
            end else if (blk == 4) begin
                // odd line of the pair is written last
                row[i*8 +: 8] = level_shift(u_at(mb * 16 + 2 * i, stripe * 16 + 2 * line + 1));
            end else begin
                row[i*8 +: 8] = level_shift(v_at(mb * 16 + 2 * i + 1,
                                                 stripe * 16 + 2 * line + 1));
            end
        end
        return row;
    endfunction

    function automatic int rand_pct();
        return $unsigned($random(seed)) % 100;
    endfunction

    task automatic check_row(input string name, input jpeg_mcu_pkg::row_t got,
                             input jpeg_mcu_pkg::row_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cnt(input string name, input logic [2:0] got, input logic [2:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        resetn            <= 1'b0;
        yuvrgb_in_valid_i <= 3'b000;
        di_hold_i         <= 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_bit("di_valid_o", di_valid_o, 1'b0);
        check_bit("yuvrgb_in_hold_o", yuvrgb_in_hold_o, 1'b0);
    endtask

    // raster source, a beat counts when offered and hold was low over the edge
    task automatic send_frame(input int stall_pct);
        int beat;
        int idle;
        int x;
        int y;
        bit offered;
        bit hold_seen;
        beat      = 0;
        idle      = 0;
        offered   = 1'b0;
        hold_seen = 1'b0;
        while (beat < FRAME_BEATS && !timed_out) begin
            @(posedge clk);
            if (offered && !hold_seen) begin
                beat++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > WAIT_LIMIT) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: input stream refused beat %0d for too long", beat);
            end
            offered = (beat < FRAME_BEATS) && (rand_pct() >= stall_pct);
            if (offered) begin
                x = beat % IMG_W;
                y = beat / IMG_W;
                pixel_count_i     <= XW'(x);
                line_count_i      <= YW'(y);
                yuvrgb_in_y_i     <= luma_at(x, y);
                // U on even columns, V on odd columns
                yuvrgb_in_u_i     <= (x % 2 == 0) ? u_at(x, y) : 8'd0;
                yuvrgb_in_v_i     <= (x % 2 == 1) ? v_at(x, y) : 8'd0;
                yuvrgb_in_valid_i <= {x % 2 == 1, x % 2 == 0, 1'b1};
            end else begin
                yuvrgb_in_valid_i <= 3'b000;
            end
            @(negedge clk);
            hold_seen = yuvrgb_in_hold_o;
            // full only with two stripes in and the first one not yet read out
            if (hold_seen && beat < FRAME_BEATS) begin
                full_seen = 1'b1;
                if (beat != 2 * STRIPE_BEATS || rows_taken >= ROWS_PER_STRIPE) begin
                    errors++;
                    $display("input hold high at time %0t after %0d beats and %0d rows",
                             $time, beat, rows_taken);
                end
            end
        end
    endtask

    // output sink with an initial stall, then random hold
    task automatic take_rows(input int hold_pct, input int init_stall, input int exp_rows);
        int                 idle;
        int                 wait_left;
        bit                 held_before;
        jpeg_mcu_pkg::row_t last_row;
        logic [2:0]         last_cnt;
        idle        = 0;
        wait_left   = init_stall;
        held_before = 1'b0;
        last_row    = '0;
        last_cnt    = 3'd0;
        while (rows_taken < exp_rows && !timed_out) begin
            @(posedge clk);
            if (wait_left > 0) begin
                di_hold_i <= 1'b1;
                wait_left--;
            end else begin
                di_hold_i <= (rand_pct() < hold_pct);
            end
            @(negedge clk);
            // a held row must still be there, unchanged
            if (held_before) begin
                check_bit("di_valid_o", di_valid_o, 1'b1);
                check_row("di_o", di_o, last_row);
                check_cnt("di_cnt_o", di_cnt_o, last_cnt);
            end
            held_before = di_valid_o && di_hold_i;
            last_row    = di_o;
            last_cnt    = di_cnt_o;
            if (di_valid_o && !di_hold_i) begin
                check_row("di_o", di_o, model_row(rows_taken));
                check_cnt("di_cnt_o", di_cnt_o, 3'(rows_taken % jpeg_mcu_pkg::MCU_ROWS));
                rows_taken++;
                idle = 0;
            end else if (wait_left == 0) begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    timed_out = 1'b1;
                    errors++;
                    $display("timeout: no output row after row %0d", rows_taken);
                end
            end
        end
    endtask

    // nothing beyond the expected rows comes out
    task automatic check_drained();
        @(posedge clk);
        di_hold_i <= 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_bit("di_valid_o", di_valid_o, 1'b0);
            check_bit("yuvrgb_in_hold_o", yuvrgb_in_hold_o, 1'b0);
        end
    endtask

    initial begin
        int t;
        int errs_before;
        resetn            <= 1'b0;
        yuvrgb_in_y_i     <= 8'd0;
        yuvrgb_in_u_i     <= 8'd0;
        yuvrgb_in_v_i     <= 8'd0;
        yuvrgb_in_valid_i <= 3'b000;
        pixel_count_i     <= '0;
        line_count_i      <= '0;
        di_hold_i         <= 1'b0;
        x_size_m1_i       <= XW'(IMG_W - 1);
        y_size_m1_i       <= YW'(IMG_H - 1);
        // di_hold %, source stall %, initial di_hold cycles, rows, input hold expected
        cases[0] = '{8'd0,  8'd0,  16'd0,    16'd288, 1'b0};
        cases[1] = '{8'd30, 8'd0,  16'd0,    16'd288, 1'b0};
        cases[2] = '{8'd0,  8'd40, 16'd0,    16'd288, 1'b0};
        cases[3] = '{8'd50, 8'd25, 16'd0,    16'd288, 1'b0};
        cases[4] = '{8'd0,  8'd0,  16'd1500, 16'd288, 1'b1};
        cases[5] = '{8'd20, 8'd20, 16'd2500, 16'd288, 1'b1};
        for (t = 0; t < NUM_CASES && !timed_out; t++) begin
            errs_before = errors;
            apply_reset();
            rows_taken = 0;
            full_seen  = 1'b0;
            fork
                send_frame(int'(cases[t].stall_pct));
                take_rows(int'(cases[t].hold_pct), int'(cases[t].init_stall),
                          int'(cases[t].exp_rows));
            join
            if (!timed_out) begin
                check_drained();
                check_bit("yuvrgb_in_hold_o risen", full_seen, cases[t].exp_full);
            end
            $display("test %0d: di_hold %0d%%, stall %0d%%, initial hold %0d, rows %0d, errors %0d",
                     t, cases[t].hold_pct, cases[t].stall_pct, cases[t].init_stall,
                     rows_taken, errors - errs_before);
        end
        $display("tests %0d, checks %0d, errors %0d", t, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src/mcu_buffer.sv
module mcu_buffer #(
    parameter int SENSOR_X_SIZE = 64,
    parameter int SENSOR_Y_SIZE = 64
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  jpeg_mcu_pkg::pixel_t                 yuvrgb_in_y_i,
    input  jpeg_mcu_pkg::pixel_t                 yuvrgb_in_u_i,
    input  jpeg_mcu_pkg::pixel_t                 yuvrgb_in_v_i,
    input  logic [2:0]                           yuvrgb_in_valid_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0]     pixel_count_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0]     line_count_i,
    output logic                                 yuvrgb_in_hold_o,
    output jpeg_mcu_pkg::row_t                   di_o,
    output logic                                 di_valid_o,
    output logic [2:0]                           di_cnt_o,
    input  logic                                 di_hold_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0]     x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0]     y_size_m1_i
);

    // two banks of one full-width stripe, eight luma samples per word
    localparam int Y_DEPTH  = 2 * SENSOR_X_SIZE * jpeg_mcu_pkg::STRIPE_LINES / 8;
    localparam int Y_AW     = $clog2(Y_DEPTH);
    // two banks, U and V, half width and half height
    localparam int UV_DEPTH = 2 * 2 * (SENSOR_X_SIZE / 2) * (jpeg_mcu_pkg::STRIPE_LINES / 2) / 8;
    localparam int UV_AW    = $clog2(UV_DEPTH);

    logic                   stripe_done;
    logic                   wr_bank;

    logic [Y_AW-1:0]        y_wa;
    jpeg_mcu_pkg::row_t     y_wd;
    jpeg_mcu_pkg::byte_en_t y_wbe;
    logic                   y_we;
    logic [UV_AW-1:0]       uv_wa;
    jpeg_mcu_pkg::row_t     uv_wd;
    jpeg_mcu_pkg::byte_en_t uv_wbe;
    logic                   uv_we;

    logic [Y_AW-1:0]        y_ra;
    logic                   y_re;
    logic [UV_AW-1:0]       uv_ra;
    logic                   uv_re;
    jpeg_mcu_pkg::row_t     y_rd;
    jpeg_mcu_pkg::row_t     uv_rd;

    logic                   advance;
    jpeg_mcu_pkg::mcu_id_e  cur_mcu;
    logic [2:0]             cur_row;

    // input hold is the sequencer's full flag
    mcu_write_port #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) i_write_port (
        .clk               (clk),
        .resetn            (resetn),
        .yuvrgb_in_y_i     (yuvrgb_in_y_i),
        .yuvrgb_in_u_i     (yuvrgb_in_u_i),
        .yuvrgb_in_v_i     (yuvrgb_in_v_i),
        .yuvrgb_in_valid_i (yuvrgb_in_valid_i),
        .pixel_count_i     (pixel_count_i),
        .line_count_i      (line_count_i),
        .x_size_m1_i       (x_size_m1_i),
        .y_size_m1_i       (y_size_m1_i),
        .in_full_i         (yuvrgb_in_hold_o),
        .wr_bank_i         (wr_bank),
        .y_wa_o            (y_wa),
        .y_wd_o            (y_wd),
        .y_wbe_o           (y_wbe),
        .y_we_o            (y_we),
        .uv_wa_o           (uv_wa),
        .uv_wd_o           (uv_wd),
        .uv_wbe_o          (uv_wbe),
        .uv_we_o           (uv_we),
        .stripe_done_o     (stripe_done)
    );

    dp_ram_be #(
        .DEPTH (Y_DEPTH),
        .AW    (Y_AW)
    ) y_ram (
        .clk   (clk),
        .wa_i  (y_wa),
        .wd_i  (y_wd),
        .wbe_i (y_wbe),
        .we_i  (y_we),
        .ra_i  (y_ra),
        .re_i  (y_re),
        .rd_o  (y_rd)
    );

    dp_ram_be #(
        .DEPTH (UV_DEPTH),
        .AW    (UV_AW)
    ) uv_ram (
        .clk   (clk),
        .wa_i  (uv_wa),
        .wd_i  (uv_wd),
        .wbe_i (uv_wbe),
        .we_i  (uv_we),
        .ra_i  (uv_ra),
        .re_i  (uv_re),
        .rd_o  (uv_rd)
    );

    mcu_read_sequencer #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) i_read_sequencer (
        .clk           (clk),
        .resetn        (resetn),
        .stripe_done_i (stripe_done),
        .di_hold_i     (di_hold_i),
        .x_size_m1_i   (x_size_m1_i),
        .y_size_m1_i   (y_size_m1_i),
        .in_full_o     (yuvrgb_in_hold_o),
        .wr_bank_o     (wr_bank),
        .y_ra_o        (y_ra),
        .y_re_o        (y_re),
        .uv_ra_o       (uv_ra),
        .uv_re_o       (uv_re),
        .advance_o     (advance),
        .cur_mcu_o     (cur_mcu),
        .cur_row_o     (cur_row)
    );

    mcu_output_stage i_output_stage (
        .clk        (clk),
        .resetn     (resetn),
        .advance_i  (advance),
        .di_hold_i  (di_hold_i),
        .cur_mcu_i  (cur_mcu),
        .cur_row_i  (cur_row),
        .y_rd_i     (y_rd),
        .uv_rd_i    (uv_rd),
        .di_o       (di_o),
        .di_valid_o (di_valid_o),
        .di_cnt_o   (di_cnt_o)
    );

endmodule

//--- src/mcu_output_stage.sv
module mcu_output_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  advance_i,
    input  logic                  di_hold_i,
    input  jpeg_mcu_pkg::mcu_id_e cur_mcu_i,
    input  logic [2:0]            cur_row_i,
    input  jpeg_mcu_pkg::row_t    y_rd_i,
    input  jpeg_mcu_pkg::row_t    uv_rd_i,
    output jpeg_mcu_pkg::row_t    di_o,
    output logic                  di_valid_o,
    output logic [2:0]            di_cnt_o
);

    // block of the row now sitting in the RAM output registers
    jpeg_mcu_pkg::mcu_id_e mcu_q;

    always_ff @(posedge clk) begin
        if (advance_i) begin
            mcu_q    <= cur_mcu_i;
            di_cnt_o <= cur_row_i;
        end
    end

    // RAM outputs already hold on stall, the select follows them
    always_comb begin
        if (mcu_q >= jpeg_mcu_pkg::MCU_U) begin
            di_o = uv_rd_i;
        end else begin
            di_o = y_rd_i;
        end
    end

    // valid one cycle after the read, frozen while held
    always_ff @(posedge clk) begin
        if (!resetn) begin
            di_valid_o <= 1'b0;
        end else if (!di_hold_i) begin
            di_valid_o <= advance_i;
        end
    end

    // a stalled row must not change under the consumer
    a_hold_stable : assert property (
        @(posedge clk) disable iff (!resetn)
        (di_valid_o && di_hold_i) |=> (di_valid_o && $stable(di_o) && $stable(di_cnt_o))
    );

endmodule

//--- src/mcu_read_sequencer.sv
module mcu_read_sequencer #(
    parameter int SENSOR_X_SIZE = 64,
    parameter int SENSOR_Y_SIZE = 64
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 stripe_done_i,
    input  logic                                 di_hold_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0]     x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0]     y_size_m1_i,
    output logic                                 in_full_o,
    output logic                                 wr_bank_o,
    output logic [$clog2(SENSOR_X_SIZE)+1:0]     y_ra_o,
    output logic                                 y_re_o,
    output logic [$clog2(SENSOR_X_SIZE):0]       uv_ra_o,
    output logic                                 uv_re_o,
    output logic                                 advance_o,
    output jpeg_mcu_pkg::mcu_id_e                cur_mcu_o,
    output logic [2:0]                           cur_row_o
);

    localparam int XW = $clog2(SENSOR_X_SIZE);

    // stripe pointers, bit 0 is the bank, bit 1 tells full from empty
    logic [1:0]            wptr;
    logic [1:0]            rptr;
    logic                  full;
    logic                  empty;
    logic                  go;
    logic                  row_last;
    logic                  blk_last;
    logic                  rd_release;

    logic [2:0]            row_cnt;
    jpeg_mcu_pkg::mcu_id_e mcu_cnt;
    logic [XW-5:0]         blk_h;

    always_comb empty = (wptr == rptr);
    always_comb full  = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);

    always_comb in_full_o = full;
    always_comb wr_bank_o = wptr[0];

    // one row read per cycle while a stripe is waiting and output is free
    always_comb go        = !di_hold_i && !empty;
    always_comb advance_o = go;

    always_comb row_last   = (row_cnt == 3'(jpeg_mcu_pkg::MCU_ROWS - 1));
    always_comb blk_last   = (blk_h == x_size_m1_i[XW-1:4]);
    // last row of V in the rightmost macroblock frees the bank
    always_comb rd_release = go && row_last && (mcu_cnt == jpeg_mcu_pkg::MCU_V) && blk_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= 2'd0;
        end else if (stripe_done_i) begin
            wptr <= wptr + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr <= 2'd0;
        end else if (rd_release) begin
            rptr <= rptr + 2'd1;
        end
    end

    // row, then block in macroblock, then macroblock across
    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_cnt <= 3'd0;
            mcu_cnt <= jpeg_mcu_pkg::MCU_Y0;
            blk_h   <= '0;
        end else if (go) begin
            row_cnt <= row_cnt + 3'd1;
            if (row_last) begin
                if (mcu_cnt == jpeg_mcu_pkg::MCU_V) begin
                    mcu_cnt <= jpeg_mcu_pkg::MCU_Y0;
                    if (blk_last) begin
                        blk_h <= '0;
                    end else begin
                        blk_h <= blk_h + 1'b1;
                    end
                end else begin
                    mcu_cnt <= jpeg_mcu_pkg::mcu_id_e'(mcu_cnt + 3'd1);
                end
            end
        end
    end

    // luma: column {block, Y1/Y3 half}, line {Y2/Y3 half, row}, bank
    always_comb y_ra_o = {blk_h, mcu_cnt[0], mcu_cnt[1], row_cnt, rptr[0]};
    always_comb y_re_o = go && (mcu_cnt <= jpeg_mcu_pkg::MCU_Y3);

    // chroma: block, line pair, bank, then bit 0 picks V over U
    always_comb uv_ra_o = {blk_h, row_cnt, rptr[0], mcu_cnt[0]};
    always_comb uv_re_o = go && (mcu_cnt >= jpeg_mcu_pkg::MCU_U);

    always_comb cur_mcu_o = mcu_cnt;
    always_comb cur_row_o = row_cnt;

    // at most two stripes in flight, one per bank
    a_ptr_span : assert property (
        @(posedge clk) disable iff (!resetn)
        2'(wptr - rptr) <= 2'd2
    );

    // write port must stop accepting once both banks are taken
    a_no_done_when_full : assert property (
        @(posedge clk) disable iff (!resetn)
        stripe_done_i |-> !full
    );

endmodule

//--- src/mcu_write_port.sv
module mcu_write_port #(
    parameter int SENSOR_X_SIZE = 64,
    parameter int SENSOR_Y_SIZE = 64
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  jpeg_mcu_pkg::pixel_t                 yuvrgb_in_y_i,
    input  jpeg_mcu_pkg::pixel_t                 yuvrgb_in_u_i,
    input  jpeg_mcu_pkg::pixel_t                 yuvrgb_in_v_i,
    input  logic [2:0]                           yuvrgb_in_valid_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0]     pixel_count_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0]     line_count_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0]     x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0]     y_size_m1_i,
    input  logic                                 in_full_i,
    input  logic                                 wr_bank_i,
    output logic [$clog2(SENSOR_X_SIZE)+1:0]     y_wa_o,
    output jpeg_mcu_pkg::row_t                   y_wd_o,
    output jpeg_mcu_pkg::byte_en_t               y_wbe_o,
    output logic                                 y_we_o,
    output logic [$clog2(SENSOR_X_SIZE):0]       uv_wa_o,
    output jpeg_mcu_pkg::row_t                   uv_wd_o,
    output jpeg_mcu_pkg::byte_en_t               uv_wbe_o,
    output logic                                 uv_we_o,
    output logic                                 stripe_done_o
);

    localparam int XW = $clog2(SENSOR_X_SIZE);

    jpeg_mcu_pkg::sample_t y_s;
    jpeg_mcu_pkg::sample_t c_s;
    logic                  v_sel;
    logic                  last_line;

    // V rides on odd-x beats, U on even-x beats, never both
    always_comb v_sel = yuvrgb_in_valid_i[2];

    // level shift, 8-bit wrap gives the signed result directly
    always_comb y_s = jpeg_mcu_pkg::sample_t'(yuvrgb_in_y_i - jpeg_mcu_pkg::JPEG_BIAS);
    always_comb begin
        if (v_sel) begin
            c_s = jpeg_mcu_pkg::sample_t'(yuvrgb_in_v_i - jpeg_mcu_pkg::JPEG_BIAS);
        end else begin
            c_s = jpeg_mcu_pkg::sample_t'(yuvrgb_in_u_i - jpeg_mcu_pkg::JPEG_BIAS);
        end
    end

    // luma word address: 8-pixel column, line within stripe, bank
    always_comb y_wa_o  = {pixel_count_i[XW-1:3], line_count_i[3:0], wr_bank_i};
    always_comb y_wd_o  = {8{y_s}};
    always_comb y_wbe_o = jpeg_mcu_pkg::byte_en_t'(1) << pixel_count_i[2:0];
    // a refused beat must not touch the RAM
    always_comb y_we_o  = yuvrgb_in_valid_i[0] && !in_full_i;

    // chroma word address: 16-pixel column, line pair, bank, U/V
    // both lines of a pair share a word, the odd line lands last
    always_comb uv_wa_o  = {pixel_count_i[XW-1:4], line_count_i[3:1], wr_bank_i, v_sel};
    always_comb uv_wd_o  = {8{c_s}};
    // lane is the subsampled column within the block
    always_comb uv_wbe_o = jpeg_mcu_pkg::byte_en_t'(1) << pixel_count_i[3:1];
    always_comb uv_we_o  = (yuvrgb_in_valid_i[1] || yuvrgb_in_valid_i[2]) && !in_full_i;

    // end of stripe on line 15, or on the final line of a short image
    always_comb begin
        last_line = (line_count_i[3:0] == 4'(jpeg_mcu_pkg::STRIPE_LINES - 1)) ||
                    (line_count_i == y_size_m1_i);
    end

    always_comb stripe_done_o = y_we_o && last_line && (pixel_count_i == x_size_m1_i);

    // source must send U and V on separate beats, else one of them is lost
    a_uv_exclusive : assert property (
        @(posedge clk) disable iff (!resetn)
        !(yuvrgb_in_valid_i[1] && yuvrgb_in_valid_i[2])
    );

endmodule

//--- src/dp_ram_be.sv
module dp_ram_be #(
    parameter int DEPTH = 256,
    parameter int AW    = 8
) (
    input  logic                   clk,
    input  logic [AW-1:0]          wa_i,
    input  jpeg_mcu_pkg::row_t     wd_i,
    input  jpeg_mcu_pkg::byte_en_t wbe_i,
    input  logic                   we_i,
    input  logic [AW-1:0]          ra_i,
    input  logic                   re_i,
    output jpeg_mcu_pkg::row_t     rd_o
);

    jpeg_mcu_pkg::row_t mem [DEPTH];

    // write side, only the enabled lanes change
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (we_i && wbe_i[i]) begin
                mem[wa_i][i*8 +: 8] <= wd_i[i*8 +: 8];
            end
        end
    end

    // read side
    // output register only loads on a read, so a stalled row stays put
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

endmodule

//--- src/jpeg_mcu_pkg.sv
package jpeg_mcu_pkg;

    // raw camera sample, one component
    typedef logic [7:0] pixel_t;

    // sample after the level shift, range -128..127
    typedef logic signed [7:0] sample_t;

    // one RAM word holds eight samples of a block row
    typedef logic [63:0] row_t;

    // one write strobe per byte lane of a row
    typedef logic [7:0] byte_en_t;

    // block order inside one 4:2:0 macroblock
    //   Y0 Y1    U    V
    //   Y2 Y3
    // bit 0 of the code picks the right luma half (and V over U)
    // bit 1 picks the lower luma half
    typedef enum logic [2:0] {
        MCU_Y0 = 3'd0,
        MCU_Y1 = 3'd1,
        MCU_Y2 = 3'd2,
        MCU_Y3 = 3'd3,
        MCU_U  = 3'd4,
        MCU_V  = 3'd5
    } mcu_id_e;

    // level shift applied before the DCT
    localparam pixel_t JPEG_BIAS = 8'd128;

    // rows in one 8x8 block
    localparam int MCU_ROWS = 8;

    // luma lines buffered per stripe, one macroblock high
    localparam int STRIPE_LINES = 16;

endpackage
